/* sources.f */
rtl/shader_pkg.sv
rtl/fpint_decode.sv
rtl/fpint_lane.sv
rtl/fpint_unit.sv
rtl/shader_alu_top.sv
test/clock_gen.sv
test/fpint_checker.sv
test/fpint_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := fpint_tb
FILE_LIST := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_TEXT := STATUS: FAIL
PASS_TEXT := STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/fpint_tb.sv */
`timescale 1ns/10ps

module fpint_tb;

	import shader_pkg::*;

	localparam int LANES = 4;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_OPS = 460;
	localparam logic [31:0] SEED = 32'h95ba9f1c;

	logic clk;
	logic rst_n;
	word a[LANES];
	word b[LANES];
	alu_op op;
	logic in_valid;
	logic out_valid;
	word q[LANES];

	// one entry per issued operation, oldest first.
	int due_cycle[$];
	logic [LANES*32-1:0] due_result[$];

	int cycle;
	int issued;
	int checked;

	clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(16)) clocks (.clk(clk), .rst_n(rst_n));

	shader_alu_top #(.LANES(LANES)) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.a(a),
		.b(b),
		.op(op),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.q(q)
	);

	bind fpint_unit fpint_checker valid_check (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.out_valid(out_valid)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input word actual, input word expected, input string what);
		if (actual !== expected)
			stop_with_failure($sformatf("MISMATCH at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	// sign, biased exponent of the leading one, next 23 bits truncated.
	function automatic word int_to_float(input word value);
		logic sign;
		word mag;
		int top;
		logic [7:0] exponent;
		logic [22:0] mantissa;

		if (value == '0)
			return '0;
		sign = value[31];
		mag = sign ? -value : value;
		top = 31;
		while (!mag[top])
			top--;
		exponent = 8'(127 + top);
		if (top >= 23)
			mantissa = 23'(mag >> (top - 23));
		else
			mantissa = 23'(mag << (23 - top));
		return {sign, exponent, mantissa};
	endfunction

	function automatic word expected_result(input alu_op code, input word x, input word y);
		case (code)
			OP_ADD: return x + y;
			OP_SUB: return x - y;
			OP_MIN: return ($signed(x) < $signed(y)) ? x : y;
			OP_MAX: return ($signed(x) > $signed(y)) ? x : y;
			OP_ABS: return x[31] ? -x : x;
			OP_ITOF: return int_to_float(x);
			default: return '0;
		endcase
	endfunction

	// edge values show up often.
	function automatic word random_word();
		case ($urandom_range(0, 7))
			0: return 32'h0000_0000;
			1: return 32'h0000_0001;
			2: return 32'h7fff_ffff;
			3: return 32'h8000_0000;
			4: return 32'hffff_ffff;
			5: return $urandom_range(0, 255);
			default: return $urandom();
		endcase
	endfunction

	task automatic issue(input alu_op code, input logic [LANES*32-1:0] a_bits,
		input logic [LANES*32-1:0] b_bits);
		logic [LANES*32-1:0] result;

		@(posedge clk);
		#DRIVE_DELAY;
		op = code;
		in_valid = 1'b1;
		for (int lane = 0; lane < LANES; lane++) begin
			a[lane] = a_bits[lane*32 +: 32];
			b[lane] = b_bits[lane*32 +: 32];
			result[lane*32 +: 32] = expected_result(code, a[lane], b[lane]);
		end
		// accepted at the next edge, q changes three edges after that.
		due_cycle.push_back(cycle + FPINT_STAGES);
		due_result.push_back(result);
		issued++;
	endtask

	task automatic issue_all_lanes(input alu_op code, input word x, input word y);
		issue(code, {LANES{x}}, {LANES{y}});
	endtask

	task automatic issue_random();
		logic [LANES*32-1:0] a_bits;
		logic [LANES*32-1:0] b_bits;
		alu_op code;

		code = alu_op'($urandom_range(0, 5));
		for (int lane = 0; lane < LANES; lane++) begin
			a_bits[lane*32 +: 32] = random_word();
			b_bits[lane*32 +: 32] = ($urandom_range(0, 7) == 0) ?
				a_bits[lane*32 +: 32] : random_word();
		end
		issue(code, a_bits, b_bits);
	endtask

	// op keeps moving while idle, it must have no effect.
	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#DRIVE_DELAY;
			in_valid = 1'b0;
			op = alu_op'($urandom_range(0, 5));
		end
	endtask

	always @(posedge clk) begin
		logic expect_valid;
		logic [LANES*32-1:0] result;

		#1;
		cycle++;
		expect_valid = due_cycle.size() != 0 && due_cycle[0] == cycle;
		check_value({31'd0, out_valid}, {31'd0, expect_valid}, "out_valid");
		if (expect_valid) begin
			void'(due_cycle.pop_front());
			result = due_result.pop_front();
			for (int lane = 0; lane < LANES; lane++)
				check_value(q[lane], result[lane*32 +: 32], $sformatf("q[%0d]", lane));
			checked++;
		end
	end

	initial begin
		#(CLK_PERIOD * (NUM_OPS * 4 + 200));
		stop_with_failure("timeout: the operations did not complete in time");
	end

	initial begin
		void'($urandom(SEED));
		cycle = 0;
		issued = 0;
		checked = 0;
		in_valid = 1'b0;
		op = OP_ADD;
		for (int lane = 0; lane < LANES; lane++) begin
			a[lane] = '0;
			b[lane] = '0;
		end

		// reset is applied first, then released.
		@(negedge rst_n);
		@(posedge rst_n);
		idle(5);

		issue_all_lanes(OP_ADD, 32'h0000_0000, 32'h0000_0000);
		issue_all_lanes(OP_ADD, 32'h0000_0001, 32'hffff_ffff);
		issue_all_lanes(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
		issue_all_lanes(OP_ADD, 32'h8000_0000, 32'h8000_0000);
		issue_all_lanes(OP_SUB, 32'h0000_0000, 32'h0000_0001);
		issue_all_lanes(OP_SUB, 32'h8000_0000, 32'h0000_0001);
		issue_all_lanes(OP_SUB, 32'h0000_0001, 32'h8000_0000);
		issue_all_lanes(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);
		issue_all_lanes(OP_MIN, 32'h0000_0005, 32'h0000_0005);
		issue_all_lanes(OP_MIN, 32'hffff_fffd, 32'h0000_0004);
		issue_all_lanes(OP_MIN, 32'h7fff_ffff, 32'h8000_0000);
		issue_all_lanes(OP_MAX, 32'h0000_0005, 32'h0000_0005);
		issue_all_lanes(OP_MAX, 32'hffff_fffd, 32'h0000_0004);
		issue_all_lanes(OP_MAX, 32'h7fff_ffff, 32'h8000_0000);
		issue_all_lanes(OP_ABS, 32'h0000_0000, 32'h1234_5678);
		issue_all_lanes(OP_ABS, 32'h8000_0000, 32'h0000_0000);
		issue_all_lanes(OP_ABS, 32'hffff_ffff, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'h0000_0000, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'h0000_0001, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'hffff_ffff, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'h8000_0000, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'h7fff_ffff, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'h01ff_ffff, 32'h0000_0000);
		issue_all_lanes(OP_ITOF, 32'hfedc_ba98, 32'h0000_0000);

		while (issued < NUM_OPS) begin
			issue_random();
			if ($urandom_range(0, 3) == 0)
				idle($urandom_range(1, 3));
		end
		idle(1);

		while (due_cycle.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);

		if (issued == NUM_OPS && checked == NUM_OPS) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stop_with_failure($sformatf("only %0d of %0d results were checked",
				checked, issued));
		end
	end

endmodule

/* test/fpint_checker.sv */
`timescale 1ns/10ps

module fpint_checker
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid
);

	import shader_pkg::*;

	// valid registers are cleared while reset is held.
	reset_clears_valid: assert property (
		@(posedge clk) !rst_n |-> !out_valid
	) else $error("out_valid was high while reset was asserted");

	// fixed latency, one valid bit per stage.
	valid_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, FPINT_STAGES)
	) else $error("out_valid does not follow in_valid by the pipeline depth");

	valid_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid)
	) else $error("out_valid is unknown after reset");

endmodule

/* test/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen
#(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset falls before the first rising edge, released just after one.
	initial begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

/* rtl/shader_alu_top.sv */
`timescale 1ns/10ps

module shader_alu_top
#(
	parameter int LANES = 4
)
(
	input  logic              clk,
	                          rst_n,

	input  shader_pkg::word   a[LANES],
	                          b[LANES],
	input  shader_pkg::alu_op op,
	input  logic              in_valid,

	output logic              out_valid,
	output shader_pkg::word   q[LANES]
);

	logic negate_b;
	logic zero_b;
	logic minmax_enable;
	logic minmax_max;
	logic abs_enable;
	logic addsub_bypass;
	logic itof_enable;

	fpint_decode decode
	(
		.op(op),
		.negate_b(negate_b),
		.zero_b(zero_b),
		.minmax_enable(minmax_enable),
		.minmax_max(minmax_max),
		.abs_enable(abs_enable),
		.addsub_bypass(addsub_bypass),
		.itof_enable(itof_enable)
	);

	fpint_unit
	#(
		.LANES(LANES)
	) unit
	(
		.clk(clk),
		.rst_n(rst_n),
		.a(a),
		.b(b),
		.in_valid(in_valid),
		.negate_b(negate_b),
		.zero_b(zero_b),
		.minmax_enable(minmax_enable),
		.minmax_max(minmax_max),
		.abs_enable(abs_enable),
		.addsub_bypass(addsub_bypass),
		.itof_enable(itof_enable),
		.out_valid(out_valid),
		.q(q)
	);

endmodule

/* rtl/fpint_unit.sv */
`timescale 1ns/10ps

module fpint_unit
#(
	parameter int LANES = 4
)
(
	input  logic            clk,
	                        rst_n,

	input  shader_pkg::word a[LANES],
	                        b[LANES],
	input  logic            in_valid,
	                        negate_b,
	                        zero_b,
	                        minmax_enable,
	                        minmax_max,
	                        abs_enable,
	                        addsub_bypass,
	                        itof_enable,

	output logic            out_valid,
	output shader_pkg::word q[LANES]
);

	import shader_pkg::*;

	logic [FPINT_STAGES-1:0] valid_pipe;

	// flag copies, named after the stage that reads them.
	logic minmax_enable_2;
	logic minmax_max_2;
	logic abs_enable_2;
	logic addsub_bypass_2;
	logic addsub_bypass_3;
	logic itof_enable_2;
	logic itof_enable_3;
	logic itof_enable_4;

	always_ff @(posedge clk) begin
		minmax_enable_2 <= minmax_enable;
		minmax_max_2 <= minmax_max;
		abs_enable_2 <= abs_enable;

		addsub_bypass_2 <= addsub_bypass;
		addsub_bypass_3 <= addsub_bypass_2;

		itof_enable_2 <= itof_enable;
		itof_enable_3 <= itof_enable_2;
		itof_enable_4 <= itof_enable_3;
	end

	// one valid bit per stage register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[FPINT_STAGES-2:0], in_valid};
	end

	assign out_valid = valid_pipe[FPINT_STAGES-1];

	genvar lane;
	generate
		for (lane = 0; lane < LANES; ++lane) begin: lanes
			fpint_lane unit
			(
				.clk(clk),
				.a(a[lane]),
				.b(b[lane]),
				.negate_b_1(negate_b),
				.zero_b_1(zero_b),
				.minmax_enable_2(minmax_enable_2),
				.minmax_max_2(minmax_max_2),
				.abs_enable_2(abs_enable_2),
				.addsub_bypass_3(addsub_bypass_3),
				.itof_enable_4(itof_enable_4),
				.q(q[lane])
			);
		end
	endgenerate

endmodule

/* rtl/fpint_lane.sv */
`timescale 1ns/10ps

module fpint_lane
(
	input  logic            clk,

	input  shader_pkg::word a,
	                        b,

	input  logic            negate_b_1,
	                        zero_b_1,
	                        minmax_enable_2,
	                        minmax_max_2,
	                        abs_enable_2,
	                        addsub_bypass_3,
	                        itof_enable_4,

	output shader_pkg::word q
);

	import shader_pkg::*;

	// first operand after stage 1 and 2, result after stage 3 and 4.
	word stage_q[1:FPINT_STAGES];

	word b_1;
	word b_2;
	logic carry_1;
	logic carry_2;
	logic sign_2;
	logic sign_3;
	logic [5:0] clz_3;

	logic a_lt_b;
	word smaller;
	word larger;
	word magnitude;
	word sum;
	word result;
	logic [5:0] lz_count;
	word normalized;
	logic [7:0] exponent;
	word encoded;

	// leading zeros, 32 for a zero word.
	function automatic logic [5:0] count_lz(input word value);
		logic [5:0] count;
		logic found;

		count = 6'd0;
		found = 1'b0;
		for (int i = 31; i >= 0; --i) begin
			if (!found) begin
				if (value[i])
					found = 1'b1;
				else
					count = count + 6'd1;
			end
		end

		return count;
	endfunction

	// stage 2 inputs.
	assign a_lt_b = $signed(stage_q[1]) < $signed(b_1);
	assign smaller = a_lt_b ? stage_q[1] : b_1;
	assign larger = a_lt_b ? b_1 : stage_q[1];

	// most negative value wraps back onto itself.
	assign magnitude = stage_q[1][31] ? ~stage_q[1] + 32'd1 : stage_q[1];

	// stage 3 inputs.
	assign sum = stage_q[2] + b_2 + {31'd0, carry_2};
	assign result = addsub_bypass_3 ? stage_q[2] : sum;
	assign lz_count = count_lz(result);

	// stage 4 inputs.
	assign normalized = stage_q[3] << clz_3;
	assign exponent = 8'd158 - {2'b00, clz_3};

	// leading one is implicit, low bits truncated.
	assign encoded = stage_q[3] == '0 ? '0 : {sign_3, exponent, normalized[30:8]};

	always_ff @(posedge clk) begin
		// stage 1.
		stage_q[1] <= a;
		carry_1 <= negate_b_1;
		if (zero_b_1)
			b_1 <= '0;
		else if (negate_b_1)
			b_1 <= ~b;
		else
			b_1 <= b;

		// stage 2.
		sign_2 <= stage_q[1][31];
		carry_2 <= carry_1;
		if (minmax_enable_2) begin
			stage_q[2] <= minmax_max_2 ? larger : smaller;
			b_2 <= '0;
		end else if (abs_enable_2) begin
			stage_q[2] <= magnitude;
			b_2 <= b_1;
		end else begin
			stage_q[2] <= stage_q[1];
			b_2 <= b_1;
		end

		// stage 3.
		stage_q[3] <= result;
		clz_3 <= lz_count;
		sign_3 <= sign_2;

		// stage 4.
		stage_q[4] <= itof_enable_4 ? encoded : stage_q[3];
	end

	assign q = stage_q[FPINT_STAGES];

endmodule

/* rtl/fpint_decode.sv */
`timescale 1ns/10ps

module fpint_decode
(
	input  shader_pkg::alu_op op,

	output logic              negate_b,
	                          zero_b,
	                          minmax_enable,
	                          minmax_max,
	                          abs_enable,
	                          addsub_bypass,
	                          itof_enable
);

	import shader_pkg::*;

	always_comb begin
		negate_b = 1'b0;
		zero_b = 1'b0;
		minmax_enable = 1'b0;
		minmax_max = 1'b0;
		abs_enable = 1'b0;
		addsub_bypass = 1'b0;
		itof_enable = 1'b0;

		case (op)
			OP_ADD: begin
			end

			// b inverted, carry in of one.
			OP_SUB:
				negate_b = 1'b1;

			OP_MIN: begin
				minmax_enable = 1'b1;
				addsub_bypass = 1'b1;
			end

			OP_MAX: begin
				minmax_enable = 1'b1;
				minmax_max = 1'b1;
				addsub_bypass = 1'b1;
			end

			OP_ABS: begin
				zero_b = 1'b1;
				abs_enable = 1'b1;
				addsub_bypass = 1'b1;
			end

			// magnitude first, then normalize and encode.
			OP_ITOF: begin
				zero_b = 1'b1;
				abs_enable = 1'b1;
				addsub_bypass = 1'b1;
				itof_enable = 1'b1;
			end

			default: begin
			end
		endcase
	end

endmodule

/* rtl/shader_pkg.sv */
package shader_pkg;

	// one lane operand or result.
	typedef logic [31:0] word;

	// operation codes seen by the decoder.
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_MIN  = 3'd2,
		OP_MAX  = 3'd3,
		OP_ABS  = 3'd4,
		OP_ITOF = 3'd5
	} alu_op;

	// register stages between operands and q.
	localparam int FPINT_STAGES = 4;

endpackage
